// ==== corr_pkg.sv ====
package corr_pkg;

   // --------------------------------------------------
   // Array and accumulator sizes
   // --------------------------------------------------
   localparam int NUM_ANT   = 12;  // Antennas, one sign bit each for re and im
   localparam int NUM_PAIRS = 12;  // Correlated pairs per pass
   localparam int ADDR_W    = 4;   // Pair address width
   localparam int ACC_W     = 12;  // Signed accumulator width
   localparam int DAT_W     = 32;  // Bus data width

   // Saturation limits of a signed ACC_W value
   localparam logic signed [ACC_W-1:0] ACC_MAX = {1'b0, {(ACC_W-1){1'b1}}};
   localparam logic signed [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W-1){1'b0}}};

   // Pair table, low nibble is antenna a, high nibble antenna b
   // Antennas 0 and 1 against the outer ring 6 to 11
   localparam logic [7:0] PAIR_TABLE [NUM_PAIRS] = '{
      8'h60, 8'h70, 8'h80, 8'h90, 8'ha0, 8'hb0,
      8'h61, 8'h71, 8'h81, 8'h91, 8'ha1, 8'hb1
   };

   // Bus register field, taken from adr bit 4
   typedef enum logic {
      BUS_COS = 1'b0,  // Cosine (real) visibility
      BUS_SIN = 1'b1   // Sine (imaginary) visibility
   } corr_field_e;

   // --------------------------------------------------
   // Pipeline items
   // --------------------------------------------------
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;   // Pair index
      logic              bank;   // Bank to write
      logic              clear;  // Start from zero
      logic              ar;     // Real bit of antenna a
      logic              br;     // Real bit of antenna b
      logic              bi;     // Imaginary bit of antenna b
   } corr_item_t;

   typedef struct packed {
      logic                    valid;
      logic [ADDR_W-1:0]       addr;
      logic                    bank;
      logic signed [ACC_W-1:0] cos;  // New cosine sum
      logic signed [ACC_W-1:0] sin;  // New sine sum
   } corr_update_t;

endpackage

// ==== corr_pair_sequencer.sv ====
`timescale 1ns/1ps

module corr_pair_sequencer (
   input  logic                         clk_x,
   input  logic                         rst,
   input  logic                         en,    // One sample per cycle
   input  logic                         sw,    // Bank switch request
   input  logic [corr_pkg::NUM_ANT-1:0] re,    // Real sign bits
   input  logic [corr_pkg::NUM_ANT-1:0] im,    // Imaginary sign bits
   output corr_pkg::corr_item_t         item,
   output logic                         bank   // Active bank
);

   import corr_pkg::*;

   logic [ADDR_W-1:0] addr;       // Current pair address
   logic              pend;       // Switch waiting for wrap
   logic              clear;      // Current pass starts from zero
   logic              wrap;
   logic [7:0]        pair_code;
   logic [3:0]        a_idx;
   logic [3:0]        b_idx;
   logic              do_switch;

   // --------------------------------------------------
   // Pair lookup
   // --------------------------------------------------
   assign pair_code = PAIR_TABLE[addr];
   assign a_idx     = pair_code[3:0];  // Low nibble
   assign b_idx     = pair_code[7:4];  // High nibble

   assign wrap      = (addr == ADDR_W'(NUM_PAIRS - 1));
   // Switch lands on the last pair of a pass, sw in that cycle counts too
   assign do_switch = en && wrap && (sw || pend);

   // Pair address counter
   always_ff @(posedge clk_x) begin
      if (rst) begin
         addr <= '0;
      end else if (en) begin
         addr <= wrap ? '0 : addr + 1'b1;
      end
   end

   // --------------------------------------------------
   // Bank switch and clear control
   // --------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         bank  <= 1'b0;
         clear <= 1'b1;  // First pass after reset from zero
         pend  <= 1'b0;
      end else if (do_switch) begin
         bank  <= ~bank;
         clear <= 1'b1;  // Next twelve items restart
         pend  <= 1'b0;
      end else begin
         if (sw) begin
            pend <= 1'b1;  // Defer to next wrap
         end
         if (en && wrap) begin
            clear <= 1'b0;  // Cleared pass finished
         end
      end
   end

   // --------------------------------------------------
   // Item register
   // --------------------------------------------------
   // Bank is captured here so in-flight writes keep the old bank
   always_ff @(posedge clk_x) begin
      if (rst) begin
         item.valid <= 1'b0;
      end else begin
         item.valid <= en;
      end
      if (en) begin
         item.addr  <= addr;
         item.bank  <= bank;
         item.clear <= clear;
         item.ar    <= re[a_idx];
         item.br    <= re[b_idx];
         item.bi    <= im[b_idx];
      end
   end

endmodule

// ==== corr_mac.sv ====
`timescale 1ns/1ps

module corr_mac (
   input  logic                              clk_x,
   input  logic                              rst,
   input  corr_pkg::corr_item_t              item,
   input  logic signed [corr_pkg::ACC_W-1:0] rd_cos,  // Stored cosine sum
   input  logic signed [corr_pkg::ACC_W-1:0] rd_sin,  // Stored sine sum
   output corr_pkg::corr_update_t            update,
   output logic                              overflow_cos,
   output logic                              overflow_sin
);

   import corr_pkg::*;

   logic [ACC_W-1:0] base_cos;   // Sum before this sample
   logic [ACC_W-1:0] base_sin;
   logic             cos_agree;  // Cosine product is +1
   logic             sin_agree;  // Sine product is +1
   logic [ACC_W:0]   step_cos;   // {saturated, new sum}
   logic [ACC_W:0]   step_sin;

   // --------------------------------------------------
   // Saturating add of a +1 or -1 product
   // --------------------------------------------------
   function automatic logic [ACC_W:0] sat_step(
      input logic [ACC_W-1:0] acc,
      input logic             agree
   );
      logic [ACC_W:0] ext;
      logic [ACC_W:0] sum;
      logic           ovf;
      ext = {acc[ACC_W-1], acc};  // One guard bit
      sum = agree ? ext + 1'b1 : ext - 1'b1;
      ovf = sum[ACC_W] ^ sum[ACC_W-1];
      if (ovf) begin
         // Guard bit gives the true sign
         return {1'b1, (sum[ACC_W] ? ACC_MIN : ACC_MAX)};
      end
      return {1'b0, sum[ACC_W-1:0]};
   endfunction

   // One-bit complex multiply, a times conjugate of b
   assign cos_agree = (item.ar == item.br);
   assign sin_agree = (item.ar == item.bi);

   // First pass after a switch ignores the stale bank
   assign base_cos = item.clear ? '0 : rd_cos;
   assign base_sin = item.clear ? '0 : rd_sin;

   assign step_cos = sat_step(base_cos, cos_agree);
   assign step_sin = sat_step(base_sin, sin_agree);

   // --------------------------------------------------
   // Update register and sticky flags
   // --------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         update.valid <= 1'b0;
         overflow_cos <= 1'b0;
         overflow_sin <= 1'b0;
      end else begin
         update.valid <= item.valid;
         if (item.valid && step_cos[ACC_W]) begin
            overflow_cos <= 1'b1;  // Held until reset
         end
         if (item.valid && step_sin[ACC_W]) begin
            overflow_sin <= 1'b1;
         end
      end
      if (item.valid) begin
         update.addr <= item.addr;
         update.bank <= item.bank;
         update.cos  <= step_cos[ACC_W-1:0];
         update.sin  <= step_sin[ACC_W-1:0];
      end
   end

endmodule

// ==== corr_accum_ram.sv ====
`timescale 1ns/1ps

module corr_accum_ram (
   input  logic                               clk_x,
   // Pipeline read port
   input  corr_pkg::corr_item_t               item,
   output logic signed [corr_pkg::ACC_W-1:0]  rd_cos,
   output logic signed [corr_pkg::ACC_W-1:0]  rd_sin,
   // Pipeline write port
   input  corr_pkg::corr_update_t             update,
   // Bus read port
   input  logic [corr_pkg::ADDR_W-1:0]        bus_addr,
   input  logic                               bus_bank,
   input  corr_pkg::corr_field_e              bus_field,
   output logic [corr_pkg::DAT_W-1:0]         bus_data
);

   import corr_pkg::*;

   // --------------------------------------------------
   // Storage, two banks per quadrature
   // --------------------------------------------------
   // Small and asynchronous read, maps to distributed RAM
   logic signed [ACC_W-1:0] cos_mem [2][NUM_PAIRS];
   logic signed [ACC_W-1:0] sin_mem [2][NUM_PAIRS];

   logic signed [ACC_W-1:0] bus_cos;  // Bus port cosine entry
   logic signed [ACC_W-1:0] bus_sin;  // Bus port sine entry
   logic signed [ACC_W-1:0] bus_sel;

   // --------------------------------------------------
   // Pipeline read port
   // --------------------------------------------------
   // Same cycle as the item, feeds the MAC directly
   assign rd_cos = cos_mem[item.bank][item.addr];
   assign rd_sin = sin_mem[item.bank][item.addr];

   // --------------------------------------------------
   // Write port
   // --------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (update.valid) begin
         cos_mem[update.bank][update.addr] <= update.cos;
         sin_mem[update.bank][update.addr] <= update.sin;
      end
   end

   // --------------------------------------------------
   // Bus read port
   // --------------------------------------------------
   // Always the inactive bank, never touched by the writes above
   assign bus_cos = cos_mem[bus_bank][bus_addr];
   assign bus_sin = sin_mem[bus_bank][bus_addr];

   always_comb begin
      case (bus_field)
         BUS_COS: bus_sel = bus_cos;
         BUS_SIN: bus_sel = bus_sin;
         default: bus_sel = '0;
      endcase
   end

   // Sign extension onto the bus width
   assign bus_data = {{(DAT_W - ACC_W){bus_sel[ACC_W-1]}}, bus_sel};

endmodule

// ==== corr_bus_reader.sv ====
`timescale 1ns/1ps

module corr_bus_reader (
   input  logic                        clk_x,
   input  logic                        rst,
   // Wishbone-like slave
   input  logic                        cyc,
   input  logic                        stb,
   input  logic                        we,    // Writes acked, no effect
   input  logic [corr_pkg::ADDR_W:0]   adr,   // {field, index}
   output logic [corr_pkg::DAT_W-1:0]  dat_o,
   output logic                        ack,
   // Active bank from the sequencer
   input  logic                        bank,
   // RAM bus port
   output logic [corr_pkg::ADDR_W-1:0] bus_addr,
   output logic                        bus_bank,
   output corr_pkg::corr_field_e       bus_field,
   input  logic [corr_pkg::DAT_W-1:0]  bus_data
);

   import corr_pkg::*;

   logic req;       // Request seen
   logic take;      // Request accepted this cycle
   logic in_range;  // Index maps to a pair

   // --------------------------------------------------
   // Address decode
   // --------------------------------------------------
   assign bus_addr  = adr[ADDR_W-1:0];
   assign bus_field = corr_field_e'(adr[ADDR_W]);  // Bit 4 picks cos or sin
   assign bus_bank  = ~bank;                        // Inactive bank only

   assign in_range  = (bus_addr < ADDR_W'(NUM_PAIRS));

   assign req  = cyc && stb;
   assign take = req && !ack;  // Held request answered every other cycle

   // --------------------------------------------------
   // Ack and data registers
   // --------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         ack <= 1'b0;
      end else begin
         ack <= take;  // One-cycle pulse
      end
      if (take) begin
         // Unused indices and writes return zero
         dat_o <= (!we && in_range) ? bus_data : '0;
      end
   end

endmodule

// ==== correlator_top.sv ====
`timescale 1ns/1ps

module correlator_top (
   input  logic                         clk_x,
   input  logic                         rst,
   // Antenna samples
   input  logic                         en,
   input  logic                         sw,
   input  logic [corr_pkg::NUM_ANT-1:0] re,
   input  logic [corr_pkg::NUM_ANT-1:0] im,
   // Visibility read bus
   input  logic                         cyc,
   input  logic                         stb,
   input  logic                         we,
   input  logic [corr_pkg::ADDR_W:0]    adr,
   output logic [corr_pkg::DAT_W-1:0]   dat_o,
   output logic                         ack,
   // Status
   output logic                         overflow_cos,
   output logic                         overflow_sin
);

   import corr_pkg::*;

   // --------------------------------------------------
   // Internal nets
   // --------------------------------------------------
   corr_item_t              item;       // Sequencer to MAC and RAM
   corr_update_t            update;     // MAC to RAM write port
   logic signed [ACC_W-1:0] rd_cos;     // Active-bank sums
   logic signed [ACC_W-1:0] rd_sin;
   logic                    bank;       // Active bank
   logic [ADDR_W-1:0]       bus_addr;
   logic                    bus_bank;
   corr_field_e             bus_field;
   logic [DAT_W-1:0]        bus_data;

   // Producer
   corr_pair_sequencer seq_i (
      .clk_x (clk_x),
      .rst   (rst),
      .en    (en),
      .sw    (sw),
      .re    (re),
      .im    (im),
      .item  (item),
      .bank  (bank)
   );

   corr_mac mac_i (
      .clk_x        (clk_x),
      .rst          (rst),
      .item         (item),
      .rd_cos       (rd_cos),
      .rd_sin       (rd_sin),
      .update       (update),
      .overflow_cos (overflow_cos),
      .overflow_sin (overflow_sin)
   );

   // Buffer
   corr_accum_ram ram_i (
      .clk_x     (clk_x),
      .item      (item),
      .rd_cos    (rd_cos),
      .rd_sin    (rd_sin),
      .update    (update),
      .bus_addr  (bus_addr),
      .bus_bank  (bus_bank),
      .bus_field (bus_field),
      .bus_data  (bus_data)
   );

   // Consumer
   corr_bus_reader bus_i (
      .clk_x     (clk_x),
      .rst       (rst),
      .cyc       (cyc),
      .stb       (stb),
      .we        (we),
      .adr       (adr),
      .dat_o     (dat_o),
      .ack       (ack),
      .bank      (bank),
      .bus_addr  (bus_addr),
      .bus_bank  (bus_bank),
      .bus_field (bus_field),
      .bus_data  (bus_data)
   );

endmodule

// ==== correlator_checker.sv ====
`timescale 1ns/1ps

module correlator_checker (
   input logic clk_x,
   input logic rst,
   input logic cyc,
   input logic stb,
   input logic ack,
   input logic overflow_cos,
   input logic overflow_sin
);

   int assert_errors = 0;  // Failed assertion count

   // --------------------------------------------------
   // Bus ack
   // --------------------------------------------------
   ack_single: assert property (@(posedge clk_x) disable iff (rst) ack |=> !ack)
      else begin
         $error("ack high two cycles in a row");
         assert_errors++;
      end

   ack_after_req: assert property (@(posedge clk_x) disable iff (rst)
                                   ack |-> $past(cyc && stb))
      else begin
         $error("ack without a request");
         assert_errors++;
      end

   // Sticky overflow flags
   ovf_cos_hold: assert property (@(posedge clk_x) disable iff (rst) !$fell(overflow_cos))
      else begin
         $error("overflow_cos fell outside reset");
         assert_errors++;
      end

   ovf_sin_hold: assert property (@(posedge clk_x) disable iff (rst) !$fell(overflow_sin))
      else begin
         $error("overflow_sin fell outside reset");
         assert_errors++;
      end

endmodule

bind correlator_top correlator_checker chk_i (
   .clk_x        (clk_x),
   .rst          (rst),
   .cyc          (cyc),
   .stb          (stb),
   .ack          (ack),
   .overflow_cos (overflow_cos),
   .overflow_sin (overflow_sin)
);

// ==== tb_correlator.sv ====
`timescale 1ns/1ps

module tb_correlator;

   import corr_pkg::*;

   // Signed ACC_W range
   localparam int SAT_HI = 2 ** (ACC_W - 1) - 1;
   localparam int SAT_LO = -(2 ** (ACC_W - 1));

   logic               clk_x;
   logic               rst;
   logic               en;
   logic               sw;
   logic [NUM_ANT-1:0] re;
   logic [NUM_ANT-1:0] im;
   logic               cyc;
   logic               stb;
   logic               we;
   logic [ADDR_W:0]    adr;
   logic [DAT_W-1:0]   dat_o;
   logic               ack;
   logic               overflow_cos;
   logic               overflow_sin;

   // Reference model with two banks of sums
   int                 m_cos [2][NUM_PAIRS];
   int                 m_sin [2][NUM_PAIRS];
   logic [ADDR_W-1:0]  m_addr;                 // Pair address
   logic               m_bank;                 // Active bank
   logic               m_clear;                // Pass starts from zero
   logic               m_pend;                 // Deferred switch
   logic               m_ovf_cos;
   logic               m_ovf_sin;
   int                 errors;
   int                 checks;
   int                 timeouts;
   integer             seed;

   correlator_top dut_i (.*);

   initial begin
      clk_x = 1'b0;
      forever #5 clk_x = ~clk_x;
   end

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   function automatic int clip(input int v, output logic hit);
      hit = (v > SAT_HI) || (v < SAT_LO);
      if (v > SAT_HI) return SAT_HI;
      if (v < SAT_LO) return SAT_LO;
      return v;
   endfunction

   task automatic model_sample(input logic [NUM_ANT-1:0] r, input logic [NUM_ANT-1:0] i,
                               input logic s);
      logic [3:0] a;
      logic [3:0] b;
      int         pc;
      int         ps;
      logic       hit;
      a  = (m_addr < 4'd6) ? 4'd0 : 4'd1;                          // Antenna 0 then 1
      b  = 4'd6 + ((m_addr < 4'd6) ? m_addr : m_addr - 4'd6);     // Outer ring 6 to 11
      pc = (r[a] == r[b]) ? 1 : -1;
      ps = (r[a] == i[b]) ? 1 : -1;
      m_cos[m_bank][m_addr] = clip((m_clear ? 0 : m_cos[m_bank][m_addr]) + pc, hit);
      m_ovf_cos = m_ovf_cos | hit;
      m_sin[m_bank][m_addr] = clip((m_clear ? 0 : m_sin[m_bank][m_addr]) + ps, hit);
      m_ovf_sin = m_ovf_sin | hit;
      if (m_addr == 4'(NUM_PAIRS - 1)) begin
         m_addr = '0;
         if (s || m_pend) begin   // Switch at the wrap
            m_bank  = ~m_bank;
            m_clear = 1'b1;
            m_pend  = 1'b0;
         end else begin
            m_clear = 1'b0;
         end
      end else begin
         m_addr = m_addr + 4'd1;
         if (s) m_pend = 1'b1;    // Held until the wrap
      end
   endtask

   // --------------------------------------------------
   // Drivers and checks
   // --------------------------------------------------
   // One clock of stimulus from 1 ns after the edge
   task automatic drive(input logic e, input logic s, input logic [NUM_ANT-1:0] r,
                        input logic [NUM_ANT-1:0] i);
      en = e;
      sw = s;
      re = r;
      im = i;
      if (e) model_sample(r, i, s);
      else if (s) m_pend = 1'b1;
      @(posedge clk_x);
      #1;
      en = 1'b0;
      sw = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk_x);
         #1;
      end
   endtask

   task automatic check_value(input logic [DAT_W-1:0] got, input logic [DAT_W-1:0] exp,
                              input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED at %0t: %s, got %0d expected %0d", $time, what,
                  $signed(got), $signed(exp));
      end
   endtask

   // Single bus cycle with w high for a write
   task automatic bus_access(input logic [ADDR_W:0] a, input logic w,
                             output logic [DAT_W-1:0] d);
      int n;
      cyc = 1'b1;
      stb = 1'b1;
      we  = w;
      adr = a;
      n   = 0;
      do begin
         @(posedge clk_x);
         #1;
         n++;
      end while (!ack && n < 20);
      if (!ack) begin
         timeouts++;
         $display("Timeout: no ack for bus address %0d", a);
      end
      d   = dat_o;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
      idle(1);  // Ack drops
   endtask

   // All 24 registers of the inactive bank
   task automatic read_all_check(input logic want_zero, input string tag);
      logic [DAT_W-1:0] d;
      logic             ib;
      ib = ~m_bank;
      for (int k = 0; k < NUM_PAIRS; k++) begin
         bus_access({1'b0, 4'(k)}, 1'b0, d);
         check_value(d, want_zero ? 32'd0 : 32'(m_cos[ib][4'(k)]),
                     $sformatf("%s cos %0d", tag, k));
         bus_access({1'b1, 4'(k)}, 1'b0, d);
         check_value(d, want_zero ? 32'd0 : 32'(m_sin[ib][4'(k)]),
                     $sformatf("%s sin %0d", tag, k));
      end
   endtask

   // Constant samples from address 0 with an optional switch on the last wrap
   task automatic run_const_passes(input int n, input logic [NUM_ANT-1:0] r,
                                   input logic [NUM_ANT-1:0] i, input logic sw_last);
      for (int p = 0; p < n; p++) begin
         for (int k = 0; k < NUM_PAIRS; k++) begin
            drive(1'b1, sw_last && (p == n - 1) && (k == NUM_PAIRS - 1), r, i);
         end
      end
   endtask

   // --------------------------------------------------
   // Tests
   // --------------------------------------------------
   task automatic test_reset();
      check_value(32'(ack), 32'd0, "ack after reset");
      check_value(32'(overflow_cos), 32'd0, "overflow_cos after reset");
      check_value(32'(overflow_sin), 32'd0, "overflow_sin after reset");
      run_const_passes(1, '1, '1, 1'b0);               // All products +1
      run_const_passes(1, 12'h003, 12'h000, 1'b1);     // All -1 for a net zero
      idle(4);
      read_all_check(1'b1, "reset");
   endtask

   task automatic test_pattern();
      logic [23:0] pat;
      for (int p = 0; p < 3; p++) begin
         for (int k = 0; k < NUM_PAIRS; k++) begin
            pat = 24'(k * 1357 + p * 911 + 24'h5a3c96);
            drive(1'b1, (p == 2) && (k == NUM_PAIRS - 1), pat[11:0], pat[23:12]);
         end
      end
      idle(4);  // Old bank settles
      read_all_check(1'b0, "pattern");
   endtask

   task automatic test_random();
      logic [31:0] rnd;
      for (int p = 0; p < 5; p++) begin
         for (int k = 0; k < NUM_PAIRS; k++) begin
            rnd = $random(seed);
            drive(1'b1, (p == 4) && (k == NUM_PAIRS - 1), rnd[11:0], rnd[23:12]);
         end
      end
      idle(4);
      read_all_check(1'b0, "random");
      // Fresh integration of one pass
      for (int k = 0; k < NUM_PAIRS; k++) begin
         rnd = $random(seed);
         drive(1'b1, k == NUM_PAIRS - 1, rnd[11:0], rnd[23:12]);
      end
      idle(4);
      read_all_check(1'b0, "second integration");
   endtask

   task automatic test_deferred_switch();
      logic [DAT_W-1:0] d;
      run_const_passes(1, 12'h0f3, 12'h5a5, 1'b0);
      for (int k = 0; k < NUM_PAIRS; k++) begin
         drive(1'b1, k == 5, 12'h0c2, 12'h3a1);  // sw at address 5
         if (k == 7) begin
            bus_access(5'd7, 1'b0, d);            // Bank not yet switched
            check_value(d, 32'(m_cos[~m_bank][4'd7]), "deferred switch, before wrap");
         end
      end
      idle(4);
      read_all_check(1'b0, "deferred switch");
   endtask

   task automatic test_saturation();
      logic [DAT_W-1:0] d;
      run_const_passes(2000, '1, '0, 1'b0);       // cos +1 and sin -1
      idle(2);
      check_value(32'(overflow_cos), 32'd0, "overflow_cos before limit");
      run_const_passes(60, '1, '0, 1'b1);
      idle(4);
      check_value(32'(overflow_cos), 32'(m_ovf_cos), "overflow_cos at limit");
      check_value(32'(overflow_sin), 32'(m_ovf_sin), "overflow_sin at limit");
      bus_access(5'd0, 1'b0, d);
      check_value(d, 32'(SAT_HI), "cos 0 saturated");
      read_all_check(1'b0, "saturation");
      run_const_passes(1, 12'h003, '0, 1'b0);     // Sticky flags
      idle(4);
      check_value(32'(overflow_cos), 32'd1, "overflow_cos held");
   endtask

   task automatic test_bus_write();
      logic [DAT_W-1:0] d;
      bus_access(5'd3, 1'b1, d);
      check_value(d, 32'd0, "write cycle data cos");
      bus_access(5'd19, 1'b1, d);
      check_value(d, 32'd0, "write cycle data sin");
      read_all_check(1'b0, "after writes");
      for (int k = NUM_PAIRS; k < 16; k++) begin
         bus_access({1'b0, 4'(k)}, 1'b0, d);
         check_value(d, 32'd0, $sformatf("unused cos %0d", k));
         bus_access({1'b1, 4'(k)}, 1'b0, d);
         check_value(d, 32'd0, $sformatf("unused sin %0d", k));
      end
   endtask

   initial begin
      seed      = 32'h55bc_c17d;
      errors    = 0;
      checks    = 0;
      timeouts  = 0;
      rst       = 1'b1;
      en        = 1'b0;
      sw        = 1'b0;
      re        = '0;
      im        = '0;
      cyc       = 1'b0;
      stb       = 1'b0;
      we        = 1'b0;
      adr       = '0;
      m_addr    = '0;
      m_bank    = 1'b0;
      m_clear   = 1'b1;
      m_pend    = 1'b0;
      m_ovf_cos = 1'b0;
      m_ovf_sin = 1'b0;
      repeat (2) @(posedge clk_x);
      #1;
      rst = 1'b0;
      test_reset();
      test_pattern();
      test_random();
      test_deferred_switch();
      test_saturation();
      test_bus_write();
      $display("Checks: %0d, value errors: %0d, timeouts: %0d, assertion errors: %0d",
               checks, errors, timeouts, dut_i.chk_i.assert_errors);
      if (errors == 0 && timeouts == 0 && dut_i.chk_i.assert_errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
corr_pkg.sv
corr_pair_sequencer.sv
corr_mac.sv
corr_accum_ram.sv
corr_bus_reader.sv
correlator_top.sv
correlator_checker.sv
tb_correlator.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_correlator
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Verification failed

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
